//--- verilog/core_pkg.sv
package core_pkg;

	typedef logic [3:0] reg_num;

	localparam reg_num R14 = 4'd14;
	localparam reg_num R15 = 4'd15;

	// The same word read as a data-processing or as a load/store instruction
	typedef union packed {
		struct packed {
			logic [3:0]  cond;
			logic [2:0]  group;
			logic [3:0]  opcode;
			logic        s;
			reg_num      rn;
			reg_num      rd;
			logic [11:0] shifter;
		} dp;
		struct packed {
			logic [3:0]  cond;
			logic [2:0]  group;
			logic        p;
			logic        u;
			logic        b;
			logic        w;
			logic        l;
			reg_num      rn;
			reg_num      rd;
			logic [11:0] offset;
		} ls;
	} insn_word;

	typedef enum logic [3:0] {
		ALU_AND, ALU_EOR, ALU_SUB, ALU_RSB,
		ALU_ADD, ALU_ADC, ALU_SBC, ALU_RSC,
		ALU_TST, ALU_TEQ, ALU_CMP, ALU_CMN,
		ALU_ORR, ALU_MOV, ALU_BIC, ALU_MVN
	} alu_op_t;

	typedef enum logic [1:0] {
		SHIFT_LSL, SHIFT_LSR, SHIFT_ASR, SHIFT_ROR
	} shift_type_t;

	localparam int FLAG_N = 3;
	localparam int FLAG_Z = 2;
	localparam int FLAG_C = 1;
	localparam int FLAG_V = 0;

	localparam logic [3:0] COND_EQ = 4'h0, COND_NE = 4'h1, COND_CS = 4'h2, COND_CC = 4'h3;
	localparam logic [3:0] COND_MI = 4'h4, COND_PL = 4'h5, COND_VS = 4'h6, COND_VC = 4'h7;
	localparam logic [3:0] COND_HI = 4'h8, COND_LS = 4'h9, COND_GE = 4'ha, COND_LT = 4'hb;
	localparam logic [3:0] COND_GT = 4'hc, COND_LE = 4'hd, COND_AL = 4'he, COND_NV = 4'hf;

	// Values of insn[27:25]
	localparam logic [2:0] GROUP_DP_REG    = 3'b000;
	localparam logic [2:0] GROUP_DP_IMM    = 3'b001;
	localparam logic [2:0] GROUP_LDST_IMM  = 3'b010;
	localparam logic [2:0] GROUP_LDST_REG  = 3'b011;
	localparam logic [2:0] GROUP_LDST_MULT = 3'b100;
	localparam logic [2:0] GROUP_BRANCH    = 3'b101;

	// Bit 4 marks a register shift amount, bit 7 with it marks the extension space
	localparam int SHIFT_REG_BIT = 4;
	localparam int EXT_BIT       = 7;

endpackage

//--- verilog/core_decode_conds.sv
`timescale 1ns/1ns

module core_decode_conds
	import core_pkg::*;
(
	input  logic [3:0] cond,
	input  logic [3:0] flags,

	output logic       execute,
	output logic       undefined
);

	logic n, z, c, v;

	assign n = flags[FLAG_N];
	assign z = flags[FLAG_Z];
	assign c = flags[FLAG_C];
	assign v = flags[FLAG_V];

	always_comb begin
		undefined = 1'b0;

		unique case (cond)
			COND_EQ: execute = z;
			COND_NE: execute = !z;
			COND_CS: execute = c;
			COND_CC: execute = !c;
			COND_MI: execute = n;
			COND_PL: execute = !n;
			COND_VS: execute = v;
			COND_VC: execute = !v;
			COND_HI: execute = c && !z;
			COND_LS: execute = !c || z;
			COND_GE: execute = n == v;
			COND_LT: execute = n != v;
			COND_GT: execute = !z && (n == v);
			COND_LE: execute = z || (n != v);
			COND_AL: execute = 1'b1;
			// NV is reserved on this core
			default: begin
				execute = 1'b0;
				undefined = 1'b1;
			end
		endcase
	end

endmodule

//--- verilog/core_decode_snd.sv
`timescale 1ns/1ns

module core_decode_snd
	import core_pkg::*;
(
	input  insn_word    insn,
	input  logic        is_imm,
	input  logic        shift_by_reg_if_reg,

	output logic [11:0] imm,
	output shift_type_t shift_type,
	output logic [4:0]  shift_imm,
	output logic        shift_by_reg,
	output reg_num      rm,
	output reg_num      rs,
	output logic        undefined
);

	assign rm = insn.dp.shifter[3:0];
	assign rs = insn.dp.shifter[11:8];

	always_comb begin
		undefined = 1'b0;

		if (is_imm) begin
			// 8-bit value rotated right by twice the rotate field
			imm = {4'b0, insn.dp.shifter[7:0]};
			shift_type = SHIFT_ROR;
			shift_imm = {insn.dp.shifter[11:8], 1'b0};
			shift_by_reg = 1'b0;
		end else begin
			imm = '0;
			shift_type = shift_type_t'(insn.dp.shifter[6:5]);
			shift_imm = insn.dp.shifter[11:7];
			shift_by_reg = shift_by_reg_if_reg && insn[SHIFT_REG_BIT];

			// Bit 4 with bit 7 is multiply, swap and halfword space, none of it handled here
			undefined = insn[SHIFT_REG_BIT] && (!shift_by_reg_if_reg || insn[EXT_BIT]);
		end
	end

endmodule

//--- verilog/core_decode_data.sv
`timescale 1ns/1ns

module core_decode_data
	import core_pkg::*;
(
	input  insn_word insn,

	output alu_op_t  op,
	output reg_num   rd,
	output reg_num   rn,
	output logic     uses_rn,
	output logic     writeback,
	output logic     update_flags,
	output logic     restore_spsr,
	output logic     snd_is_imm,
	output logic     snd_shift_by_reg_if_reg
);

	logic is_compare;

	assign op = alu_op_t'(insn.dp.opcode);
	assign rd = insn.dp.rd;
	assign rn = insn.dp.rn;

	// TST, TEQ, CMP and CMN sit at opcodes 10xx
	assign is_compare = insn.dp.opcode[3:2] == 2'b10;

	assign uses_rn = !(op inside {ALU_MOV, ALU_MVN});
	assign writeback = !is_compare;

	// With rd as the PC the S bit copies SPSR into CPSR instead of setting flags
	assign update_flags = insn.dp.s && (is_compare || rd != R15);
	assign restore_spsr = insn.dp.s && !is_compare && rd == R15;

	assign snd_is_imm = insn.dp.group == GROUP_DP_IMM;
	assign snd_shift_by_reg_if_reg = insn.dp.group == GROUP_DP_REG;

endmodule

//--- verilog/core_decode_ldst.sv
`timescale 1ns/1ns

module core_decode_ldst
	import core_pkg::*;
(
	input  insn_word    insn,
	input  logic        multiple,

	output logic        load,
	output logic        byte_access,
	output logic        pre_index,
	output logic        base_writeback,
	output logic [15:0] reg_list,
	output alu_op_t     addr_op,
	output reg_num      rn,
	output reg_num      rd,
	output logic        offset_is_imm,
	output logic        restore_spsr
);

	assign load = insn.ls.l;
	assign pre_index = insn.ls.p;
	assign rn = insn.ls.rn;
	assign rd = insn.ls.rd;

	// In block transfers the B position holds the S bit instead
	assign byte_access = !multiple && insn.ls.b;

	// Post-indexed single transfers always update the base
	assign base_writeback = insn.ls.w || (!multiple && !insn.ls.p);

	assign reg_list = multiple ? {insn.ls.rd, insn.ls.offset} : 16'h0000;

	assign addr_op = insn.ls.u ? ALU_ADD : ALU_SUB;

	// The I bit of single transfers is inverted relative to data processing
	assign offset_is_imm = !insn.ls.group[0];

	// LDM with S and the PC in the list returns from an exception
	assign restore_spsr = multiple && insn.ls.b && insn.ls.l && reg_list[15];

endmodule

//--- verilog/core_decode.sv
`timescale 1ns/1ns

module core_decode
	import core_pkg::*;
(
	input  insn_word    insn,
	input  logic [3:0]  flags,

	output logic        execute,
	output logic        undefined,
	output logic        writeback,
	output logic        update_flags,
	output logic        restore_spsr,
	output logic        branch,
	output logic [23:0] branch_offset,
	output alu_op_t     alu_op,
	output reg_num      rd,
	output reg_num      rn,
	output logic        uses_rn,
	output logic [11:0] snd_imm,
	output logic        snd_is_imm,
	output shift_type_t snd_shift_type,
	output logic [4:0]  snd_shift_imm,
	output logic        snd_shift_by_reg,
	output reg_num      snd_rm,
	output reg_num      snd_rs,
	output logic        mem_enable,
	output logic        mem_load,
	output logic        mem_byte,
	output logic        mem_pre_index,
	output logic        mem_base_writeback,
	output logic [15:0] mem_reg_list
);

	logic cond_execute, cond_undefined, group_undefined;
	logic is_ldst_single, is_ldst_multiple;

	logic op2_sel_imm, op2_sel_reg_shift;
	logic [11:0] op2_imm;
	shift_type_t op2_shift_type;
	logic [4:0] op2_shift_imm;
	logic op2_shift_by_reg, op2_undefined;
	reg_num op2_rm, op2_rs;

	alu_op_t data_op;
	reg_num data_rd, data_rn;
	logic data_uses_rn, data_writeback, data_update_flags, data_restore_spsr;
	logic data_snd_is_imm, data_snd_shift_by_reg_if_reg;

	logic ldst_load, ldst_byte, ldst_pre_index, ldst_base_writeback;
	logic ldst_offset_is_imm, ldst_restore_spsr;
	logic [15:0] ldst_reg_list;
	alu_op_t ldst_addr_op;
	reg_num ldst_rn, ldst_rd;

	assign is_ldst_single = insn.dp.group inside {GROUP_LDST_IMM, GROUP_LDST_REG};
	assign is_ldst_multiple = insn.dp.group == GROUP_LDST_MULT;

	assign op2_sel_imm = is_ldst_single ? ldst_offset_is_imm : data_snd_is_imm;
	assign op2_sel_reg_shift = data_snd_shift_by_reg_if_reg;

	core_decode_conds u_conds (
		.cond      (insn.dp.cond),
		.flags     (flags),
		.execute   (cond_execute),
		.undefined (cond_undefined)
	);

	core_decode_snd u_snd (
		.insn                (insn),
		.is_imm              (op2_sel_imm),
		.shift_by_reg_if_reg (op2_sel_reg_shift),
		.imm                 (op2_imm),
		.shift_type          (op2_shift_type),
		.shift_imm           (op2_shift_imm),
		.shift_by_reg        (op2_shift_by_reg),
		.rm                  (op2_rm),
		.rs                  (op2_rs),
		.undefined           (op2_undefined)
	);

	core_decode_data u_data (
		.insn                    (insn),
		.op                      (data_op),
		.rd                      (data_rd),
		.rn                      (data_rn),
		.uses_rn                 (data_uses_rn),
		.writeback               (data_writeback),
		.update_flags            (data_update_flags),
		.restore_spsr            (data_restore_spsr),
		.snd_is_imm              (data_snd_is_imm),
		.snd_shift_by_reg_if_reg (data_snd_shift_by_reg_if_reg)
	);

	core_decode_ldst u_ldst (
		.insn           (insn),
		.multiple       (is_ldst_multiple),
		.load           (ldst_load),
		.byte_access    (ldst_byte),
		.pre_index      (ldst_pre_index),
		.base_writeback (ldst_base_writeback),
		.reg_list       (ldst_reg_list),
		.addr_op        (ldst_addr_op),
		.rn             (ldst_rn),
		.rd             (ldst_rd),
		.offset_is_imm  (ldst_offset_is_imm),
		.restore_spsr   (ldst_restore_spsr)
	);

	always_comb begin
		unique case (insn.dp.group)
			// A compare without S is MRS, MSR or BX, so it neither writes nor sets flags
			GROUP_DP_REG, GROUP_DP_IMM:
				group_undefined = op2_undefined || (!data_writeback && !data_update_flags);
			GROUP_LDST_IMM, GROUP_LDST_REG: group_undefined = op2_undefined;
			GROUP_LDST_MULT, GROUP_BRANCH:  group_undefined = 1'b0;
			default:                        group_undefined = 1'b1;
		endcase
	end

	assign undefined = cond_undefined || group_undefined;
	assign execute = cond_execute && !group_undefined;

	always_comb begin
		writeback = 1'b0;
		update_flags = 1'b0;
		restore_spsr = 1'b0;
		branch = 1'b0;
		branch_offset = '0;
		alu_op = ALU_AND;
		rd = '0;
		rn = '0;
		uses_rn = 1'b0;
		snd_imm = '0;
		snd_is_imm = 1'b0;
		snd_shift_type = SHIFT_LSL;
		snd_shift_imm = '0;
		snd_shift_by_reg = 1'b0;
		snd_rm = '0;
		snd_rs = '0;
		mem_enable = 1'b0;
		mem_load = 1'b0;
		mem_byte = 1'b0;
		mem_pre_index = 1'b0;
		mem_base_writeback = 1'b0;
		mem_reg_list = '0;

		if (!undefined) begin
			unique case (insn.dp.group)
				GROUP_BRANCH: begin
					branch = 1'b1;
					branch_offset = insn[23:0];
					// Link computes PC - 4 into R14, which is the next instruction
					if (insn[24]) begin
						alu_op = ALU_SUB;
						rd = R14;
						rn = R15;
						uses_rn = 1'b1;
						snd_imm = 12'd4;
						snd_is_imm = 1'b1;
						writeback = 1'b1;
					end
				end
				GROUP_DP_REG, GROUP_DP_IMM: begin
					alu_op = data_op;
					rd = data_rd;
					rn = data_rn;
					uses_rn = data_uses_rn;
					writeback = data_writeback;
					update_flags = data_update_flags;
					restore_spsr = data_restore_spsr;
					snd_imm = op2_imm;
					snd_is_imm = data_snd_is_imm;
					snd_shift_type = op2_shift_type;
					snd_shift_imm = op2_shift_imm;
					snd_shift_by_reg = op2_shift_by_reg;
					snd_rm = op2_rm;
					snd_rs = op2_rs;
				end
				GROUP_LDST_IMM, GROUP_LDST_REG: begin
					mem_byte = ldst_byte;
					snd_is_imm = ldst_offset_is_imm;
					// Offsets are a plain 12-bit value, never rotated
					if (ldst_offset_is_imm) begin
						snd_imm = insn.ls.offset;
					end else begin
						snd_shift_type = op2_shift_type;
						snd_shift_imm = op2_shift_imm;
						snd_rm = op2_rm;
					end
				end
				GROUP_LDST_MULT: begin
					mem_reg_list = ldst_reg_list;
					restore_spsr = ldst_restore_spsr;
					snd_imm = 12'd4;
					snd_is_imm = 1'b1;
				end
				default: ;
			endcase

			// Both transfer kinds drive the ALU as the address adder
			if (is_ldst_single || is_ldst_multiple) begin
				mem_enable = 1'b1;
				mem_load = ldst_load;
				mem_pre_index = ldst_pre_index;
				mem_base_writeback = ldst_base_writeback;
				alu_op = ldst_addr_op;
				rd = ldst_rd;
				rn = ldst_rn;
				uses_rn = 1'b1;
				writeback = ldst_base_writeback || ldst_load;
			end
		end
	end

endmodule

//--- verilog/core_decode_stage.sv
`timescale 1ns/1ns

module core_decode_stage
	import core_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  logic [31:0] insn,
	input  logic [3:0]  flags,

	output logic        out_valid,
	output logic        execute,
	output logic        undefined,
	output logic        writeback,
	output logic        update_flags,
	output logic        restore_spsr,
	output logic        branch,
	output logic [23:0] branch_offset,
	output alu_op_t     alu_op,
	output reg_num      rd,
	output reg_num      rn,
	output logic        uses_rn,
	output logic [11:0] snd_imm,
	output logic        snd_is_imm,
	output shift_type_t snd_shift_type,
	output logic [4:0]  snd_shift_imm,
	output logic        snd_shift_by_reg,
	output reg_num      snd_rm,
	output reg_num      snd_rs,
	output logic        mem_enable,
	output logic        mem_load,
	output logic        mem_byte,
	output logic        mem_pre_index,
	output logic        mem_base_writeback,
	output logic [15:0] mem_reg_list
);

	logic d_execute, d_undefined, d_writeback, d_update_flags, d_restore_spsr, d_branch;
	logic [23:0] d_branch_offset;
	alu_op_t d_alu_op;
	reg_num d_rd, d_rn, d_snd_rm, d_snd_rs;
	logic d_uses_rn, d_snd_is_imm, d_snd_shift_by_reg;
	logic [11:0] d_snd_imm;
	shift_type_t d_snd_shift_type;
	logic [4:0] d_snd_shift_imm;
	logic d_mem_enable, d_mem_load, d_mem_byte, d_mem_pre_index, d_mem_base_writeback;
	logic [15:0] d_mem_reg_list;

	core_decode u_core_decode (
		.insn               (insn),
		.flags              (flags),
		.execute            (d_execute),
		.undefined          (d_undefined),
		.writeback          (d_writeback),
		.update_flags       (d_update_flags),
		.restore_spsr       (d_restore_spsr),
		.branch             (d_branch),
		.branch_offset      (d_branch_offset),
		.alu_op             (d_alu_op),
		.rd                 (d_rd),
		.rn                 (d_rn),
		.uses_rn            (d_uses_rn),
		.snd_imm            (d_snd_imm),
		.snd_is_imm         (d_snd_is_imm),
		.snd_shift_type     (d_snd_shift_type),
		.snd_shift_imm      (d_snd_shift_imm),
		.snd_shift_by_reg   (d_snd_shift_by_reg),
		.snd_rm             (d_snd_rm),
		.snd_rs             (d_snd_rs),
		.mem_enable         (d_mem_enable),
		.mem_load           (d_mem_load),
		.mem_byte           (d_mem_byte),
		.mem_pre_index      (d_mem_pre_index),
		.mem_base_writeback (d_mem_base_writeback),
		.mem_reg_list       (d_mem_reg_list)
	);

	// Control bits are qualified by the valid strobe so idle cycles do nothing downstream
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			execute <= 1'b0;
			undefined <= 1'b0;
			writeback <= 1'b0;
			update_flags <= 1'b0;
			restore_spsr <= 1'b0;
			branch <= 1'b0;
			mem_enable <= 1'b0;
		end else begin
			out_valid <= in_valid;
			execute <= in_valid && d_execute;
			undefined <= in_valid && d_undefined;
			writeback <= in_valid && d_writeback;
			update_flags <= in_valid && d_update_flags;
			restore_spsr <= in_valid && d_restore_spsr;
			branch <= in_valid && d_branch;
			mem_enable <= in_valid && d_mem_enable;
		end
	end

	always_ff @(posedge clk) begin
		branch_offset <= d_branch_offset;
		alu_op <= d_alu_op;
		rd <= d_rd;
		rn <= d_rn;
		uses_rn <= d_uses_rn;
		snd_imm <= d_snd_imm;
		snd_is_imm <= d_snd_is_imm;
		snd_shift_type <= d_snd_shift_type;
		snd_shift_imm <= d_snd_shift_imm;
		snd_shift_by_reg <= d_snd_shift_by_reg;
		snd_rm <= d_snd_rm;
		snd_rs <= d_snd_rs;
		mem_load <= d_mem_load;
		mem_byte <= d_mem_byte;
		mem_pre_index <= d_mem_pre_index;
		mem_base_writeback <= d_mem_base_writeback;
		mem_reg_list <= d_mem_reg_list;
	end

	// A block transfer that executes moves at least one register
	assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && insn[27:25] == GROUP_LDST_MULT |=> !execute || mem_reg_list != 16'h0000);

endmodule

//--- bench/core_decode_tb.sv
`timescale 1ns/1ns

module core_decode_tb;

	localparam int NUM_VECTORS = 36;
	localparam int WORDS_PER_VECTOR = 5;
	localparam int RESET_CYCLES = 10;
	localparam int MAX_IDLE = 2;
	localparam int CYCLE_LIMIT = RESET_CYCLES + NUM_VECTORS * (MAX_IDLE + 1) + 20;

	logic clk;
	logic rst_n;
	logic in_valid;
	logic [31:0] insn;
	logic [3:0] flags;

	logic out_valid, execute, undefined, writeback, update_flags, restore_spsr, branch;
	logic [23:0] branch_offset;
	logic [3:0] alu_op, rd, rn, snd_rm, snd_rs;
	logic uses_rn, snd_is_imm, snd_shift_by_reg;
	logic [11:0] snd_imm;
	logic [1:0] snd_shift_type;
	logic [4:0] snd_shift_imm;
	logic mem_enable, mem_load, mem_byte, mem_pre_index, mem_base_writeback;
	logic [15:0] mem_reg_list;

	logic [31:0] vectors [0:NUM_VECTORS*WORDS_PER_VECTOR-1];
	logic [31:0] rnd_state;
	int errors;
	int test_errors;
	int idle_cycles;
	int idle;
	int cycle_count = 0;
	bit pending;
	int pending_index;

	core_decode_stage u_core_decode_stage (
		.clk                (clk),
		.rst_n              (rst_n),
		.in_valid           (in_valid),
		.insn               (insn),
		.flags              (flags),
		.out_valid          (out_valid),
		.execute            (execute),
		.undefined          (undefined),
		.writeback          (writeback),
		.update_flags       (update_flags),
		.restore_spsr       (restore_spsr),
		.branch             (branch),
		.branch_offset      (branch_offset),
		.alu_op             (alu_op),
		.rd                 (rd),
		.rn                 (rn),
		.uses_rn            (uses_rn),
		.snd_imm            (snd_imm),
		.snd_is_imm         (snd_is_imm),
		.snd_shift_type     (snd_shift_type),
		.snd_shift_imm      (snd_shift_imm),
		.snd_shift_by_reg   (snd_shift_by_reg),
		.snd_rm             (snd_rm),
		.snd_rs             (snd_rs),
		.mem_enable         (mem_enable),
		.mem_load           (mem_load),
		.mem_byte           (mem_byte),
		.mem_pre_index      (mem_pre_index),
		.mem_base_writeback (mem_base_writeback),
		.mem_reg_list       (mem_reg_list)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic compare_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected) begin
			$display("FAILED %s: got %h, expected %h", name, got, expected);
			errors++;
			test_errors++;
		end
	endtask

	// Expected fields are unpacked from the five words of one vector line
	task automatic check_vector(input int idx);
		logic [31:0] w_insn, w_ctrl, w_snd, w_offset, w_list;
		logic [11:0] bits;
		w_insn = vectors[idx*WORDS_PER_VECTOR];
		w_ctrl = vectors[idx*WORDS_PER_VECTOR + 1];
		w_snd = vectors[idx*WORDS_PER_VECTOR + 2];
		w_offset = vectors[idx*WORDS_PER_VECTOR + 3];
		w_list = vectors[idx*WORDS_PER_VECTOR + 4];
		bits = w_ctrl[27:16];
		test_errors = 0;
		compare_value("out_valid", 32'(out_valid), 32'd1);
		compare_value("execute", 32'(execute), 32'(bits[11]));
		compare_value("undefined", 32'(undefined), 32'(bits[10]));
		compare_value("writeback", 32'(writeback), 32'(bits[9]));
		compare_value("update_flags", 32'(update_flags), 32'(bits[8]));
		compare_value("restore_spsr", 32'(restore_spsr), 32'(bits[7]));
		compare_value("branch", 32'(branch), 32'(bits[6]));
		compare_value("mem_enable", 32'(mem_enable), 32'(bits[5]));
		compare_value("mem_load", 32'(mem_load), 32'(bits[4]));
		compare_value("mem_byte", 32'(mem_byte), 32'(bits[3]));
		compare_value("mem_pre_index", 32'(mem_pre_index), 32'(bits[2]));
		compare_value("mem_base_writeback", 32'(mem_base_writeback), 32'(bits[1]));
		compare_value("uses_rn", 32'(uses_rn), 32'(bits[0]));
		compare_value("alu_op", 32'(alu_op), 32'(w_ctrl[15:12]));
		compare_value("rd", 32'(rd), 32'(w_ctrl[11:8]));
		compare_value("rn", 32'(rn), 32'(w_ctrl[7:4]));
		compare_value("snd_is_imm", 32'(snd_is_imm), 32'(w_ctrl[3]));
		compare_value("snd_shift_by_reg", 32'(snd_shift_by_reg), 32'(w_ctrl[2]));
		compare_value("snd_shift_type", 32'(snd_shift_type), 32'(w_ctrl[1:0]));
		compare_value("snd_imm", 32'(snd_imm), 32'(w_snd[31:20]));
		compare_value("snd_shift_imm", 32'(snd_shift_imm), 32'(w_snd[19:12]));
		compare_value("snd_rm", 32'(snd_rm), 32'(w_snd[11:8]));
		compare_value("snd_rs", 32'(snd_rs), 32'(w_snd[7:4]));
		compare_value("branch_offset", 32'(branch_offset), w_offset);
		compare_value("mem_reg_list", 32'(mem_reg_list), w_list);
		if (test_errors == 0)
			$display("vector %0d insn %h: ok", idx, w_insn);
		else
			$display("vector %0d insn %h: %0d mismatches", idx, w_insn, test_errors);
	endtask

	// An empty slot must leave no control bit set downstream
	task automatic check_idle();
		test_errors = 0;
		compare_value("out_valid", 32'(out_valid), 32'd0);
		compare_value("execute", 32'(execute), 32'd0);
		compare_value("undefined", 32'(undefined), 32'd0);
		compare_value("writeback", 32'(writeback), 32'd0);
		compare_value("update_flags", 32'(update_flags), 32'd0);
		compare_value("restore_spsr", 32'(restore_spsr), 32'd0);
		compare_value("branch", 32'(branch), 32'd0);
		compare_value("mem_enable", 32'(mem_enable), 32'd0);
		idle_cycles++;
	endtask

	// Drives one slot and checks the slot that the stage registered on this edge
	task automatic run_slot(input bit drive_vector, input int idx);
		@(posedge clk);
		if (drive_vector) begin
			in_valid <= 1'b1;
			insn <= vectors[idx*WORDS_PER_VECTOR];
			flags <= vectors[idx*WORDS_PER_VECTOR + 1][31:28];
		end else begin
			in_valid <= 1'b0;
		end
		@(negedge clk);
		if (pending)
			check_vector(pending_index);
		else
			check_idle();
		pending = drive_vector;
		pending_index = idx;
	endtask

	initial begin
		rst_n <= 1'b0;
		in_valid <= 1'b0;
		insn <= '0;
		flags <= '0;
		errors = 0;
		idle_cycles = 0;
		pending = 1'b0;
		pending_index = 0;
		rnd_state = 32'h2dfc325a;
		$readmemh("bench/decode_stimulus.mem", vectors);

		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;

		if ($isunknown(vectors[NUM_VECTORS*WORDS_PER_VECTOR - 1])) begin
			$display("The stimulus file holds fewer vectors than expected");
			errors++;
		end else begin
			for (int i = 0; i < NUM_VECTORS; i++) begin
				rnd_state = xorshift(rnd_state);
				idle = int'(rnd_state % (MAX_IDLE + 1));
				repeat (idle) run_slot(1'b0, 0);
				run_slot(1'b1, i);
			end
			run_slot(1'b0, 0);
		end

		$display("%0d vectors, %0d idle cycles, %0d errors", NUM_VECTORS, idle_cycles, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

//--- bench/decode_stimulus.mem
// insn | flags,ctrl[11:0],alu_op,rd,rn,{snd_is_imm,snd_shift_by_reg,snd_shift_type} | snd_imm,shift_imm,rm,rs,0 | branch_offset | reg_list
// ctrl: execute undefined writeback update_flags, restore_spsr branch mem_enable mem_load, mem_byte mem_pre_index mem_base_writeback uses_rn
// Conditions on MOV r1, #5
03a01005 4a00d10b 00500500 000000 0000
03a01005 0200d10b 00500500 000000 0000
13a01005 0a00d10b 00500500 000000 0000
23a01005 2a00d10b 00500500 000000 0000
33a01005 2200d10b 00500500 000000 0000
43a01005 8a00d10b 00500500 000000 0000
63a01005 1a00d10b 00500500 000000 0000
83a01005 2a00d10b 00500500 000000 0000
83a01005 6200d10b 00500500 000000 0000
a3a01005 9a00d10b 00500500 000000 0000
b3a01005 8a00d10b 00500500 000000 0000
c3a01005 0a00d10b 00500500 000000 0000
c3a01005 4200d10b 00500500 000000 0000
d3a01005 1a00d10b 00500500 000000 0000
f3a01005 04000000 00000000 000000 0000
// Data processing
e29324ff 0b01423b 0ff08f40 000000 0000
e0454186 0a012450 00003610 000000 0000
e1b07958 0b00d706 00012890 000000 0000
e3510000 0901a01b 00000000 000000 0000
e25ef004 0a812feb 00400400 000000 0000
e1020003 04000000 00000000 000000 0000
e18bc86a 0a01ccb3 00010a80 000000 0000
// Branch, branch-link, branch-link with a failing condition
ea123456 08400000 00000000 123456 0000
ebfffffe 0a412ef8 00400000 fffffe 0000
1b000010 42412ef8 00400000 000010 0000
// Single load and store
e5b21010 0a374128 01000000 000000 0000
e4443004 0a2b2348 00400000 000000 0000
e7965107 0a354560 00002700 000000 0000
e70980ca 08252892 00001a00 000000 0000
e7965117 04000000 00000000 000000 0000
// Load and store multiple
e92d4ff0 0a2724d8 00400000 000000 4ff0
e8fd8ff0 0ab348d8 00400000 000000 8ff0
e9d00006 0a354008 00400000 000000 0006
// Multiply, coprocessor load, SWI
e0000291 04000000 00000000 000000 0000
ed912a00 04000000 00000000 000000 0000
ef000011 04000000 00000000 000000 0000

//--- files.f
verilog/core_pkg.sv
verilog/core_decode_conds.sv
verilog/core_decode_snd.sv
verilog/core_decode_data.sv
verilog/core_decode_ldst.sv
verilog/core_decode.sv
verilog/core_decode_stage.sv
bench/core_decode_tb.sv

//--- run.sh
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ns \
	--top-module core_decode_tb -Mdir obj_dir -f files.f

./obj_dir/Vcore_decode_tb | tee /dev/stderr | grep -x '>>> PASS' > /dev/null

echo "Simulation passed"
